// ==== build.f ====
src/pkg_tpu.sv
src/ma_unit.sv
src/idiv_unit.sv
src/cnvt_unit.sv
src/srl_unit.sv
src/alu.sv
src/issue_stage.sv
src/exe_lane.sv
verification/tb_exe_lane.sv

// ==== verification/tb_exe_lane.sv ====
// Testbench for the execute lane: stimulus table, host driver, result monitor, compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_exe_lane
	import pkg_tpu::*;
();

	localparam int NUM_ROWS		= 31;
	localparam int MIX_DIV		= 24;	// DIV that opens the mixed stream
	localparam int MIX_LAST		= 29;	// Last quick op behind it
	localparam int HS_TIMEOUT	= 100;	// Cycles per handshake phase
	localparam int END_TIMEOUT	= 400;
	localparam int IDLE_CYCLES	= 8;

	logic		clock = 1'b0;
	logic		arst_n;
	logic		cmd_req;
	op_t		cmd_op;
	dst_t		cmd_dst;
	data_t		cmd_src1;
	data_t		cmd_src2;
	data_t		cmd_src3;
	logic		cmd_ack;
	logic		wb_valid;
	issue_no_t	wb_issue_no;
	dst_t		wb_dst;
	data_t		wb_data;

	op_t		tab_op [NUM_ROWS];
	dst_t		tab_dst [NUM_ROWS];
	data_t		tab_src1 [NUM_ROWS];
	data_t		tab_src2 [NUM_ROWS];
	data_t		tab_src3 [NUM_ROWS];
	data_t		tab_exp [NUM_ROWS];
	issue_no_t	exp_issue [NUM_ROWS];	// Running count at accept
	bit			seen [NUM_ROWS];
	int			arrive [NUM_ROWS];		// Arrival order on write-back
	int			n_rows = 0;
	int			accepted = 0;
	int			result_cnt = 0;

	exe_lane exe_lane_i (
		.clock(clock), .arst_n(arst_n),
		.cmd_req(cmd_req), .cmd_op(cmd_op), .cmd_dst(cmd_dst),
		.cmd_src1(cmd_src1), .cmd_src2(cmd_src2), .cmd_src3(cmd_src3),
		.cmd_ack(cmd_ack),
		.wb_valid(wb_valid), .wb_issue_no(wb_issue_no), .wb_dst(wb_dst), .wb_data(wb_data)
	);

	always #4 clock = ~clock;	// 8 ns period

	//////////////////////////////
	// Failure and compare tasks
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
	endtask

	task automatic check_dst(input string name, input dst_t got, input dst_t exp);
		if (got !== exp)
			abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
	endtask

	function automatic bit is_divide(input op_t op);
		return (op == OP_DIV) || (op == OP_REM);
	endfunction

	// Accepted row that was given this issue number, or -1
	function automatic int row_of_issue(input issue_no_t issue);
		for (int i = 0; i < accepted; i++) begin
			if (exp_issue[i] == issue)
				return i;
		end
		return -1;
	endfunction

	//////////////////////////////
	// Stimulus table
	task automatic add_row(input op_t op, input dst_t dst, input data_t s1, input data_t s2,
		input data_t s3, input data_t exp);
		tab_op[n_rows]		= op;
		tab_dst[n_rows]		= dst;
		tab_src1[n_rows]	= s1;
		tab_src2[n_rows]	= s2;
		tab_src3[n_rows]	= s3;
		tab_exp[n_rows]		= exp;
		n_rows++;
	endtask

	task automatic load_table();
		add_row(OP_ADD, 5'd1, 32'h0000_0005, 32'h0000_0007, 32'h0, 32'h0000_000C);
		add_row(OP_ADD, 5'd2, 32'hFFFF_FFFF, 32'h0000_0002, 32'h0, 32'h0000_0001);	// Wraps
		add_row(OP_SUB, 5'd3, 32'h0000_0003, 32'h0000_0005, 32'h0, 32'hFFFF_FFFE);
		add_row(OP_MUL, 5'd4, 32'h0001_0000, 32'h0001_0003, 32'h0, 32'h0003_0000);
		add_row(OP_MUL, 5'd5, 32'h1234_5678, 32'h0000_0010, 32'h0, 32'h2345_6780);
		add_row(OP_MAD, 5'd6, 32'h0000_0006, 32'h0000_0007, 32'h8, 32'h0000_0032);
		add_row(OP_MAD, 5'd7, 32'hFFFF_FFFF, 32'h0000_0002, 32'h5, 32'h0000_0003);
		add_row(OP_DIV, 5'd8, 32'd100, 32'd7, 32'h0, 32'd14);
		add_row(OP_REM, 5'd9, 32'd100, 32'd7, 32'h0, 32'd2);
		add_row(OP_DIV, 5'd10, 32'hFFFF_FFFF, 32'h0000_0010, 32'h0, 32'h0FFF_FFFF);
		add_row(OP_DIV, 5'd11, 32'h0000_1234, 32'h0, 32'h0, 32'hFFFF_FFFF);	// Zero divisor
		add_row(OP_REM, 5'd12, 32'h0000_1234, 32'h0, 32'h0, 32'h0000_1234);
		add_row(OP_I2F, 5'd13, 32'h0000_0000, 32'h0, 32'h0, 32'h0000_0000);
		add_row(OP_I2F, 5'd14, 32'h0000_0001, 32'h0, 32'h0, 32'h3F80_0000);
		add_row(OP_I2F, 5'd15, 32'hFFFF_FFFF, 32'h0, 32'h0, 32'hBF80_0000);
		add_row(OP_I2F, 5'd16, 32'h7FFF_FFFF, 32'h0, 32'h0, 32'h4EFF_FFFF);	// Truncated
		add_row(OP_I2F, 5'd17, 32'hFEFF_FFFD, 32'h0, 32'h0, 32'hCB80_0001);	// -(2^24+3)
		add_row(OP_SLL, 5'd18, 32'h0000_0001, 32'h0000_0024, 32'h0, 32'h0000_0010);
		add_row(OP_SRL, 5'd19, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0, 32'h0000_0001);
		add_row(OP_SRA, 5'd20, 32'h8000_0000, 32'h0000_0004, 32'h0, 32'hF800_0000);
		add_row(OP_ROL, 5'd21, 32'h8000_0001, 32'h0000_0021, 32'h0, 32'h0000_0003);
		add_row(OP_AND, 5'd22, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0, 32'hF000_F000);
		add_row(OP_OR, 5'd23, 32'hF0F0_F0F0, 32'h0F00_000F, 32'h0, 32'hFFF0_F0FF);
		add_row(OP_XOR, 5'd24, 32'hFFFF_0000, 32'h0F0F_0F0F, 32'h0, 32'hF0F0_0F0F);
		// Mixed stream, quick ops overtake the DIV
		add_row(OP_DIV, 5'd25, 32'h0000_03E8, 32'h0000_000A, 32'h0, 32'h0000_0064);
		add_row(OP_ADD, 5'd26, 32'h0000_0010, 32'h0000_0020, 32'h0, 32'h0000_0030);
		add_row(OP_I2F, 5'd27, 32'h0000_0100, 32'h0, 32'h0, 32'h4380_0000);
		add_row(OP_XOR, 5'd28, 32'hAAAA_AAAA, 32'h5555_5555, 32'h0, 32'hFFFF_FFFF);
		add_row(OP_MUL, 5'd29, 32'h0000_FFFF, 32'h0000_FFFF, 32'h0, 32'hFFFE_0001);
		add_row(OP_SRA, 5'd30, 32'hFFFF_FF00, 32'h0000_0008, 32'h0, 32'hFFFF_FFFF);
		add_row(OP_REM, 5'd31, 32'h0000_03E9, 32'h0000_000A, 32'h0, 32'h0000_0001);
	endtask

	//////////////////////////////
	// Host driver
	task automatic send_command(input int r);
		int wait_cnt;
		@(posedge clock);
		cmd_req		<= 1'b1;
		cmd_op		<= tab_op[r];
		cmd_dst		<= tab_dst[r];
		cmd_src1	<= tab_src1[r];
		cmd_src2	<= tab_src2[r];
		cmd_src3	<= tab_src3[r];
		wait_cnt = 0;
		do begin
			@(negedge clock);
			wait_cnt++;
		end while (cmd_ack !== 1'b1 && wait_cnt < HS_TIMEOUT);
		if (cmd_ack !== 1'b1)
			abort_run($sformatf("Timed out waiting for cmd_ack to rise on row %0d", r));
		// Divider busy until its earlier result is written back
		if (is_divide(tab_op[r])) begin
			for (int i = 0; i < r; i++) begin
				if (is_divide(tab_op[i]) && !seen[i])
					abort_run($sformatf("Row %0d acked before divide row %0d wrote back", r, i));
			end
		end
		exp_issue[r] = issue_no_t'(accepted);
		accepted++;
		@(posedge clock);
		cmd_req <= 1'b0;
		wait_cnt = 0;
		do begin
			@(negedge clock);
			wait_cnt++;
		end while (cmd_ack !== 1'b0 && wait_cnt < HS_TIMEOUT);
		if (cmd_ack !== 1'b0)
			abort_run($sformatf("Timed out waiting for cmd_ack to fall on row %0d", r));
	endtask

	//////////////////////////////
	// Result monitor
	always @(negedge clock) begin : result_monitor
		int r;
		if (arst_n === 1'b1 && wb_valid === 1'b1) begin
			r = row_of_issue(wb_issue_no);
			if (r < 0)
				abort_run($sformatf("Result for issue %0d matches no accepted command",
					wb_issue_no));
			if (seen[r])
				abort_run($sformatf("Issue %0d was written back twice", wb_issue_no));
			check_dst("wb_dst", wb_dst, tab_dst[r]);
			check_data("wb_data", wb_data, tab_exp[r]);
			seen[r]		= 1'b1;
			arrive[r]	= result_cnt;
			result_cnt++;
		end
	end

	initial begin
		bit order_ok;
		int wait_cnt;
		arst_n		= 1'b0;
		cmd_req		= 1'b0;
		cmd_op		= OP_ADD;
		cmd_dst		= '0;
		cmd_src1	= '0;
		cmd_src2	= '0;
		cmd_src3	= '0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			seen[i]		= 1'b0;
			arrive[i]	= 0;
		end
		load_table();
		repeat (5) @(posedge clock);
		arst_n <= 1'b1;

		// Quiet lane with no request
		repeat (IDLE_CYCLES) begin
			@(negedge clock);
			check_bit("cmd_ack", cmd_ack, 1'b0);
			check_bit("wb_valid", wb_valid, 1'b0);
		end

		for (int r = 0; r < n_rows; r++)
			send_command(r);

		wait_cnt = 0;
		do begin
			@(posedge clock);
			wait_cnt++;
		end while (result_cnt < n_rows && wait_cnt < END_TIMEOUT);
		if (result_cnt < n_rows)
			abort_run("Timed out waiting for all write-back results");

		order_ok = 1'b1;
		for (int i = MIX_DIV + 1; i <= MIX_LAST; i++) begin
			if (arrive[i] > arrive[MIX_DIV])
				order_ok = 1'b0;
		end
		if (order_ok) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			abort_run("A quick result in the mixed stream arrived after the DIV result");
		end
	end

endmodule

`default_nettype wire

// ==== src/exe_lane.sv ====
// Execute lane top: issue stage feeding the ALU
`timescale 1ns/1ps
`default_nettype none

module exe_lane
	import pkg_tpu::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		cmd_req,
	input	op_t		cmd_op,
	input	dst_t		cmd_dst,
	input	data_t		cmd_src1,
	input	data_t		cmd_src2,
	input	data_t		cmd_src3,
	output	logic		cmd_ack,
	output	logic		wb_valid,
	output	issue_no_t	wb_issue_no,
	output	dst_t		wb_dst,
	output	data_t		wb_data
);

	logic [NUM_UNITS-1:0]	unit_ready;
	logic					disp_en;
	op_t					disp_op;
	dst_t					disp_dst;
	issue_no_t				disp_issue_no;
	data_t					disp_src1;
	data_t					disp_src2;
	data_t					disp_src3;
	issue_no_t				cur_issue_no;	// Reference for result age

	issue_stage issue_stage_i (
		.clock(clock), .arst_n(arst_n),
		.cmd_req(cmd_req), .cmd_op(cmd_op), .cmd_dst(cmd_dst),
		.cmd_src1(cmd_src1), .cmd_src2(cmd_src2), .cmd_src3(cmd_src3),
		.unit_ready(unit_ready), .cmd_ack(cmd_ack),
		.disp_en(disp_en), .disp_op(disp_op), .disp_dst(disp_dst),
		.disp_issue_no(disp_issue_no),
		.disp_src1(disp_src1), .disp_src2(disp_src2), .disp_src3(disp_src3),
		.cur_issue_no(cur_issue_no)
	);

	alu alu_i (
		.clock(clock), .arst_n(arst_n),
		.disp_en(disp_en), .disp_op(disp_op), .disp_dst(disp_dst),
		.disp_issue_no(disp_issue_no),
		.disp_src1(disp_src1), .disp_src2(disp_src2), .disp_src3(disp_src3),
		.cur_issue_no(cur_issue_no), .unit_ready(unit_ready),
		.wb_valid(wb_valid), .wb_issue_no(wb_issue_no), .wb_dst(wb_dst), .wb_data(wb_data)
	);

endmodule

`default_nettype wire

// ==== src/issue_stage.sv ====
// Issue stage: four-phase command intake, issue numbering, target readiness check
`timescale 1ns/1ps
`default_nettype none

module issue_stage
	import pkg_tpu::*;
(
	input	logic					clock,
	input	logic					arst_n,
	input	logic					cmd_req,
	input	op_t					cmd_op,
	input	dst_t					cmd_dst,
	input	data_t					cmd_src1,
	input	data_t					cmd_src2,
	input	data_t					cmd_src3,
	input	logic [NUM_UNITS-1:0]	unit_ready,
	output	logic					cmd_ack,
	output	logic					disp_en,
	output	op_t					disp_op,
	output	dst_t					disp_dst,
	output	issue_no_t				disp_issue_no,
	output	data_t					disp_src1,
	output	data_t					disp_src2,
	output	data_t					disp_src3,
	output	issue_no_t				cur_issue_no
);

	typedef enum logic {
		IDLE,
		ACKED
	} hs_state_t;

	hs_state_t	state;
	issue_no_t	issue_cnt;
	logic		accept;

	// Take the command only when its unit can start
	assign accept		= (state == IDLE) & cmd_req & unit_ready[unit_of(cmd_op)];
	assign cmd_ack		= (state == ACKED);
	assign cur_issue_no	= issue_cnt;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state		<= IDLE;
			disp_en		<= 1'b0;
			issue_cnt	<= '0;
		end else begin
			disp_en <= accept;	// Pulse with the rising ack
			if (accept) begin
				state		<= ACKED;
				issue_cnt	<= issue_cnt + 1'b1;
			end else if (state == ACKED && !cmd_req) begin
				state <= IDLE;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			disp_op			<= cmd_op;
			disp_dst		<= cmd_dst;
			disp_issue_no	<= issue_cnt;
			disp_src1		<= cmd_src1;
			disp_src2		<= cmd_src2;
			disp_src3		<= cmd_src3;
		end
	end

	a_cmd_stable: assert property (@(posedge clock) disable iff (!arst_n)
		(cmd_req && !cmd_ack) |=> (cmd_req && $stable(cmd_op) && $stable(cmd_dst)
			&& $stable(cmd_src1) && $stable(cmd_src2) && $stable(cmd_src3)));

endmodule

`default_nettype wire

// ==== src/alu.sv ====
// ALU: dispatch decode, four execution units, oldest-first write-back arbiter
`timescale 1ns/1ps
`default_nettype none

module alu
	import pkg_tpu::*;
(
	input	logic					clock,
	input	logic					arst_n,
	input	logic					disp_en,
	input	op_t					disp_op,
	input	dst_t					disp_dst,
	input	issue_no_t				disp_issue_no,
	input	data_t					disp_src1,
	input	data_t					disp_src2,
	input	data_t					disp_src3,
	input	issue_no_t				cur_issue_no,
	output	logic [NUM_UNITS-1:0]	unit_ready,
	output	logic					wb_valid,
	output	issue_no_t				wb_issue_no,
	output	dst_t					wb_dst,
	output	data_t					wb_data
);

	logic [NUM_UNITS-1:0]	en_vec;
	logic [NUM_UNITS-1:0]	done_vec;
	logic [NUM_UNITS-1:0]	grant;
	issue_no_t				res_issue [NUM_UNITS];
	dst_t					res_dst [NUM_UNITS];
	data_t					res_data [NUM_UNITS];
	issue_no_t				life [NUM_UNITS];
	issue_no_t				best_life;
	logic					found;
	unit_t					sel;

	//////////////////////////////
	// Dispatch
	assign en_vec = disp_en ? (NUM_UNITS'(1) << unit_of(disp_op)) : '0;

	ma_unit ma_unit_i (
		.clock(clock), .arst_n(arst_n),
		.en(en_vec[UNIT_MA]), .op(disp_op), .issue_no(disp_issue_no), .dst(disp_dst),
		.src1(en_vec[UNIT_MA] ? disp_src1 : '0),
		.src2(en_vec[UNIT_MA] ? disp_src2 : '0),
		.src3(en_vec[UNIT_MA] ? disp_src3 : '0),
		.grant(grant[UNIT_MA]), .ready(unit_ready[UNIT_MA]), .done(done_vec[UNIT_MA]),
		.res_issue_no(res_issue[UNIT_MA]), .res_dst(res_dst[UNIT_MA]),
		.res_data(res_data[UNIT_MA])
	);

	idiv_unit idiv_unit_i (
		.clock(clock), .arst_n(arst_n),
		.en(en_vec[UNIT_DIV]), .op(disp_op), .issue_no(disp_issue_no), .dst(disp_dst),
		.src1(en_vec[UNIT_DIV] ? disp_src1 : '0),
		.src2(en_vec[UNIT_DIV] ? disp_src2 : '0),
		.grant(grant[UNIT_DIV]), .ready(unit_ready[UNIT_DIV]), .done(done_vec[UNIT_DIV]),
		.res_issue_no(res_issue[UNIT_DIV]), .res_dst(res_dst[UNIT_DIV]),
		.res_data(res_data[UNIT_DIV])
	);

	cnvt_unit cnvt_unit_i (
		.clock(clock), .arst_n(arst_n),
		.en(en_vec[UNIT_CNVT]), .issue_no(disp_issue_no), .dst(disp_dst),
		.src1(en_vec[UNIT_CNVT] ? disp_src1 : '0),
		.grant(grant[UNIT_CNVT]), .ready(unit_ready[UNIT_CNVT]), .done(done_vec[UNIT_CNVT]),
		.res_issue_no(res_issue[UNIT_CNVT]), .res_dst(res_dst[UNIT_CNVT]),
		.res_data(res_data[UNIT_CNVT])
	);

	srl_unit srl_unit_i (
		.clock(clock), .arst_n(arst_n),
		.en(en_vec[UNIT_SRL]), .op(disp_op), .issue_no(disp_issue_no), .dst(disp_dst),
		.src1(en_vec[UNIT_SRL] ? disp_src1 : '0),
		.src2(en_vec[UNIT_SRL] ? disp_src2 : '0),
		.grant(grant[UNIT_SRL]), .ready(unit_ready[UNIT_SRL]), .done(done_vec[UNIT_SRL]),
		.res_issue_no(res_issue[UNIT_SRL]), .res_dst(res_dst[UNIT_SRL]),
		.res_data(res_data[UNIT_SRL])
	);

	//////////////////////////////
	// Oldest-first arbiter
	always_comb begin
		found		= 1'b0;
		sel			= UNIT_MA;
		best_life	= '0;
		for (int i = 0; i < NUM_UNITS; i++) begin
			life[i] = cur_issue_no - res_issue[i];	// Modulo the issue width
			// Strict compare keeps the lower unit on a tie
			if (done_vec[i] && (!found || life[i] > best_life)) begin
				found		= 1'b1;
				sel			= unit_t'(i);
				best_life	= life[i];
			end
		end
	end

	assign grant = found ? (NUM_UNITS'(1) << sel) : '0;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= found;
	end

	always_ff @(posedge clock) begin
		if (found) begin
			wb_issue_no	<= res_issue[sel];
			wb_dst		<= res_dst[sel];
			wb_data		<= res_data[sel];
		end
	end

	// A waiting result stays put until its grant
	for (genvar i = 0; i < NUM_UNITS; i++) begin : g_hold
		a_hold_until_grant: assert property (@(posedge clock) disable iff (!arst_n)
			done_vec[i] && !grant[i] |=> done_vec[i] && $stable(res_issue[i])
				&& $stable(res_data[i]));
	end

endmodule

`default_nettype wire

// ==== src/srl_unit.sv ====
// Shift, rotate and bitwise logic unit with one result hold register
`timescale 1ns/1ps
`default_nettype none

module srl_unit
	import pkg_tpu::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		en,
	input	op_t		op,
	input	issue_no_t	issue_no,
	input	dst_t		dst,
	input	data_t		src1,
	input	data_t		src2,
	input	logic		grant,
	output	logic		ready,
	output	logic		done,
	output	issue_no_t	res_issue_no,
	output	dst_t		res_dst,
	output	data_t		res_data
);

	logic [WIDTH_SHAMT-1:0]		sh;
	logic [2*WIDTH_DATA-1:0]	dbl;	// Doubled word for rotate
	data_t						res;

	assign sh	= src2[WIDTH_SHAMT-1:0];
	assign dbl	= {src1, src1} << sh;

	always_comb begin
		case (op)
			OP_SLL:		res = src1 << sh;
			OP_SRL:		res = src1 >> sh;
			OP_SRA:		res = $signed(src1) >>> sh;
			OP_ROL:		res = dbl[2*WIDTH_DATA-1 -: WIDTH_DATA];
			OP_AND:		res = src1 & src2;
			OP_OR:		res = src1 | src2;
			OP_XOR:		res = src1 ^ src2;
			default:	res = '0;
		endcase
	end

	assign ready = ~done | grant;	// Free next cycle

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			done <= 1'b0;
		else if (en)
			done <= 1'b1;
		else if (grant)
			done <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (en) begin
			res_data		<= res;
			res_issue_no	<= issue_no;
			res_dst			<= dst;
		end
	end

endmodule

`default_nettype wire

// ==== src/cnvt_unit.sv ====
// Signed integer to single precision float, truncating, with one result hold register
`timescale 1ns/1ps
`default_nettype none

module cnvt_unit
	import pkg_tpu::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		en,
	input	issue_no_t	issue_no,
	input	dst_t		dst,
	input	data_t		src1,
	input	logic		grant,
	output	logic		ready,
	output	logic		done,
	output	issue_no_t	res_issue_no,
	output	dst_t		res_dst,
	output	data_t		res_data
);

	logic					sign;
	data_t					mag;
	logic [WIDTH_SHAMT-1:0]	lead;		// Position of leading one
	data_t					norm;
	logic [WIDTH_EXP-1:0]	expo;
	data_t					fp;

	assign sign	= src1[WIDTH_DATA-1];
	assign mag	= sign ? (~src1 + data_t'(1)) : src1;	// Most negative value stays exact

	always_comb begin
		lead = '0;
		for (int i = 0; i < WIDTH_DATA; i++) begin
			if (mag[i])
				lead = WIDTH_SHAMT'(i);
		end
	end

	assign norm	= mag << (WIDTH_SHAMT'(WIDTH_DATA - 1) - lead);	// Leading one to the MSB
	assign expo	= WIDTH_EXP'(FP_BIAS) + WIDTH_EXP'(lead);
	assign fp	= (mag == '0) ? '0 : {sign, expo, norm[WIDTH_DATA-2 -: WIDTH_MANT]};

	assign ready = ~done | grant;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			done <= 1'b0;
		else if (en)
			done <= 1'b1;
		else if (grant)
			done <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (en) begin
			res_data		<= fp;
			res_issue_no	<= issue_no;
			res_dst			<= dst;
		end
	end

endmodule

`default_nettype wire

// ==== src/idiv_unit.sv ====
// Unsigned restoring divider, quotient or remainder after DIV_STEPS iterations
`timescale 1ns/1ps
`default_nettype none

module idiv_unit
	import pkg_tpu::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		en,
	input	op_t		op,
	input	issue_no_t	issue_no,
	input	dst_t		dst,
	input	data_t		src1,
	input	data_t		src2,
	input	logic		grant,
	output	logic		ready,
	output	logic		done,
	output	issue_no_t	res_issue_no,
	output	dst_t		res_dst,
	output	data_t		res_data
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		HOLD
	} div_state_t;

	div_state_t					state;
	logic [WIDTH_DIV_CNT-1:0]	cnt;
	data_t						quo;		// Dividend shifts out, quotient shifts in
	data_t						rem;
	data_t						dvs;
	op_t						op_q;
	logic [WIDTH_DATA:0]		part;
	logic						take;
	data_t						diff;

	// Partial remainder with the next dividend bit
	assign part	= {rem, quo[WIDTH_DATA-1]};
	assign take	= part >= {1'b0, dvs};	// Always true for a zero divisor
	assign diff	= part[WIDTH_DATA-1:0] - dvs;

	assign ready		= (state == IDLE);
	assign done			= (state == HOLD);
	assign res_data		= (op_q == OP_REM) ? rem : quo;

	//////////////////////////////
	// Control
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state	<= IDLE;
			cnt		<= '0;
		end else begin
			case (state)
				IDLE: if (en) begin
					state	<= RUN;
					cnt		<= '0;
				end
				RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == WIDTH_DIV_CNT'(DIV_STEPS - 1))
						state <= HOLD;
				end
				HOLD: if (grant) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Datapath
	always_ff @(posedge clock) begin
		if (state == IDLE && en) begin
			quo				<= src1;
			rem				<= '0;
			dvs				<= src2;
			op_q			<= op;
			res_issue_no	<= issue_no;
			res_dst			<= dst;
		end else if (state == RUN) begin
			quo <= {quo[WIDTH_DATA-2:0], take};
			rem <= take ? diff : part[WIDTH_DATA-1:0];
		end
	end

	a_en_in_idle: assert property (@(posedge clock) disable iff (!arst_n)
		en |-> state == IDLE);

endmodule

`default_nettype wire

// ==== src/ma_unit.sv ====
// Multiply-add unit: three stage pipeline with global stall on an ungranted result
`timescale 1ns/1ps
`default_nettype none

module ma_unit
	import pkg_tpu::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		en,
	input	op_t		op,
	input	issue_no_t	issue_no,
	input	dst_t		dst,
	input	data_t		src1,
	input	data_t		src2,
	input	data_t		src3,
	input	logic		grant,
	output	logic		ready,
	output	logic		done,
	output	issue_no_t	res_issue_no,
	output	dst_t		res_dst,
	output	data_t		res_data
);

	logic					stall;
	logic [DEPTH_MA-1:0]	vld;			// One valid bit per stage
	data_t					x_in;
	data_t					y_in;
	data_t					s1_x;
	data_t					s1_y;
	data_t					s2_sum;
	data_t					s3_data;
	issue_no_t				tok_issue [DEPTH_MA];
	dst_t					tok_dst [DEPTH_MA];

	assign stall		= vld[DEPTH_MA-1] & ~grant;
	// Dispatch lands a cycle after ready, so stage 2 must not be about to fill the hold
	assign ready		= ~stall & ~vld[DEPTH_MA-2];
	assign done			= vld[DEPTH_MA-1];
	assign res_issue_no	= tok_issue[DEPTH_MA-1];
	assign res_dst		= tok_dst[DEPTH_MA-1];
	assign res_data		= s3_data;

	// Stage 1 operands, product bypassed for ADD and SUB
	always_comb begin
		x_in = src1;
		y_in = src2;
		case (op)
			OP_SUB: y_in = ~src2 + data_t'(1);
			OP_MUL: begin
				x_in = src1 * src2;	// Low word only
				y_in = '0;
			end
			OP_MAD: begin
				x_in = src1 * src2;
				y_in = src3;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			vld <= '0;
		end else if (!stall) begin
			vld <= {vld[DEPTH_MA-2:0], en};
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			s1_x		<= x_in;
			s1_y		<= y_in;
			s2_sum		<= s1_x + s1_y;
			s3_data		<= s2_sum;		// Hold stage
			tok_issue[0]	<= issue_no;
			tok_dst[0]		<= dst;
			for (int i = 1; i < DEPTH_MA; i++) begin
				tok_issue[i]	<= tok_issue[i-1];
				tok_dst[i]		<= tok_dst[i-1];
			end
		end
	end

	a_no_en_in_stall: assert property (@(posedge clock) disable iff (!arst_n)
		en |-> !stall);

endmodule

`default_nettype wire

// ==== src/pkg_tpu.sv ====
// Widths, data types, opcode and unit enums, latencies and the op to unit map
`default_nettype none

package pkg_tpu;

	//////////////////////////////
	// Widths
	localparam int WIDTH_DATA		= 32;
	localparam int WIDTH_ISSUE		= 6;
	localparam int WIDTH_DST		= 5;
	localparam int WIDTH_SHAMT		= $clog2(WIDTH_DATA);	// Shift amount, leading one index
	localparam int NUM_UNITS		= 4;

	// Single precision fields
	localparam int WIDTH_EXP		= 8;
	localparam int WIDTH_MANT		= 23;
	localparam int FP_BIAS			= 127;

	//////////////////////////////
	// Latencies
	localparam int DEPTH_MA			= 3;	// Multiply, add, hold
	localparam int DIV_STEPS		= 32;	// One quotient bit per step
	localparam int WIDTH_DIV_CNT	= $clog2(DIV_STEPS);

	typedef logic [WIDTH_DATA-1:0]	data_t;
	typedef logic [WIDTH_ISSUE-1:0]	issue_no_t;	// Wraps, compared by difference only
	typedef logic [WIDTH_DST-1:0]	dst_t;

	typedef enum logic [3:0] {
		OP_ADD	= 4'd0,
		OP_SUB	= 4'd1,
		OP_MUL	= 4'd2,
		OP_MAD	= 4'd3,
		OP_DIV	= 4'd4,
		OP_REM	= 4'd5,
		OP_I2F	= 4'd6,
		OP_SLL	= 4'd7,
		OP_SRL	= 4'd8,
		OP_SRA	= 4'd9,
		OP_ROL	= 4'd10,
		OP_AND	= 4'd11,
		OP_OR	= 4'd12,
		OP_XOR	= 4'd13
	} op_t;

	// Order sets arbitration priority on equal life
	typedef enum logic [1:0] {
		UNIT_MA		= 2'd0,
		UNIT_DIV	= 2'd1,
		UNIT_CNVT	= 2'd2,
		UNIT_SRL	= 2'd3
	} unit_t;

	function automatic unit_t unit_of(input op_t op);
		case (op)
			OP_ADD, OP_SUB, OP_MUL, OP_MAD:	return UNIT_MA;
			OP_DIV, OP_REM:					return UNIT_DIV;
			OP_I2F:							return UNIT_CNVT;
			default:						return UNIT_SRL;	// Shifts and logic
		endcase
	endfunction

endpackage

`default_nettype wire
